/* design/gi_pkg.sv */
package gi_pkg;

    // ----------------------------------------------------------------------
    // scalar types
    // ----------------------------------------------------------------------
    typedef logic [7:0] pixel_t;

    // one gradient component, range -255 .. 255
    typedef logic signed [9:0] grad_comp_t;

    // gradient memory word, gx in [19:10], gy in [9:0]
    typedef logic [19:0] grad_t;

    // covers a 256 x 256 frame
    typedef logic [15:0] addr_t;

    typedef logic [7:0] coord_t;

    // ----------------------------------------------------------------------
    // stream beats
    // ----------------------------------------------------------------------
    // fetch -> window, y is the fetch row and runs one past the image
    typedef struct packed {
        pixel_t pix;
        coord_t x;
        coord_t y;
    } pix_beat_s;

    // window -> calculator
    typedef struct packed {
        pixel_t cur;
        pixel_t right;
        pixel_t lower;
        addr_t  addr;
    } win_beat_s;

    // gradient memory write request
    typedef struct packed {
        addr_t addr;
        grad_t data;
    } grad_wr_s;

    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_run,
        ctrl_finish
    } ctrl_state_e;

endpackage

/* design/pixel_fetch.sv */
`timescale 1ns/1ps

module pixel_fetch import gi_pkg::*; #(
    parameter int IMG_W = 256,
    parameter int IMG_H = 256
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      frame_start,
    output logic      img_rd,
    output addr_t     img_addr,
    input  pixel_t    img_di,
    output logic      pix_valid,
    input  logic      pix_ready,
    output pix_beat_s pix_beat
);

    // row counter has to reach IMG_H for the replayed row
    localparam int ROW_W = $clog2(IMG_H + 1);

    logic             active_q;
    coord_t           x_q;
    logic [ROW_W-1:0] row_q;
    logic [ROW_W-1:0] row_mem;
    logic             last_x;
    logic             last_row;

    // read in flight and its tag
    logic             pend_q;
    coord_t           tag_x_q;
    coord_t           tag_y_q;

    // two-entry output buffer
    pix_beat_s        buf_q [2];
    logic             wr_ptr_q;
    logic             rd_ptr_q;
    logic [1:0]       cnt_q;
    logic             pop;
    logic [2:0]       occ_next;

    // ----------------------------------------------------------------------
    // read issue
    // ----------------------------------------------------------------------
    assign last_x   = (x_q == coord_t'(IMG_W - 1));
    assign last_row = (row_q == ROW_W'(IMG_H));
    assign row_mem  = last_row ? ROW_W'(IMG_H - 1) : row_q;

    assign pop      = pix_valid && pix_ready;
    assign occ_next = 3'(cnt_q) + 3'(pend_q) - 3'(pop);

    // the answer lands next cycle, so leave one slot free for it
    assign img_rd   = active_q && (occ_next < 3'd2);
    assign img_addr = addr_t'(row_mem) * addr_t'(IMG_W) + addr_t'(x_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            active_q <= 1'b0;
            x_q      <= '0;
            row_q    <= '0;
            pend_q   <= 1'b0;
        end else begin
            pend_q <= img_rd;
            if (frame_start) begin
                active_q <= 1'b1;
                x_q      <= '0;
                row_q    <= '0;
            end else if (img_rd) begin
                if (last_x) begin
                    x_q   <= '0;
                    row_q <= row_q + 1'b1;
                    if (last_row) begin
                        active_q <= 1'b0;
                    end
                end else begin
                    x_q <= x_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (img_rd) begin
            tag_x_q <= x_q;
            tag_y_q <= coord_t'(row_q);
        end
    end

    // ----------------------------------------------------------------------
    // capture buffer
    // ----------------------------------------------------------------------
    assign pix_valid = (cnt_q != 2'd0);
    assign pix_beat  = buf_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            if (pend_q) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            cnt_q <= occ_next[1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (pend_q) begin
            buf_q[wr_ptr_q] <= '{pix: img_di, x: tag_x_q, y: tag_y_q};
        end
    end

endmodule

/* design/window_gen.sv */
`timescale 1ns/1ps

module window_gen import gi_pkg::*; #(
    parameter int IMG_W = 256
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      pix_valid,
    output logic      pix_ready,
    input  pix_beat_s pix_beat,
    output logic      win_valid,
    input  logic      win_ready,
    output win_beat_s win_beat
);

    // line_q[k] holds the pixel accepted k beats ago
    pixel_t    line_q [1:IMG_W];
    logic      accept;
    logic      emit;
    logic      last_col;
    coord_t    row_above;
    win_beat_s win_next;
    logic      win_valid_q;
    win_beat_s win_beat_q;

    assign pix_ready = !win_valid_q || win_ready;
    assign accept    = pix_valid && pix_ready;

    // row 0 only fills the line
    assign emit      = accept && (pix_beat.y != '0);
    assign last_col  = (pix_beat.x == coord_t'(IMG_W - 1));
    assign row_above = pix_beat.y - coord_t'(1);

    // ----------------------------------------------------------------------
    // window for column x of the row above the incoming pixel
    // ----------------------------------------------------------------------
    always_comb begin
        win_next.cur   = line_q[IMG_W];
        // replicate the edge pixel past the last column
        win_next.right = last_col ? line_q[IMG_W] : line_q[IMG_W - 1];
        win_next.lower = pix_beat.pix;
        win_next.addr  = addr_t'(row_above) * addr_t'(IMG_W) + addr_t'(pix_beat.x);
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            line_q[1] <= pix_beat.pix;
            for (int i = 2; i <= IMG_W; i++) begin
                line_q[i] <= line_q[i - 1];
            end
        end
    end

    // ----------------------------------------------------------------------
    // output stage
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            win_valid_q <= 1'b0;
        end else if (emit) begin
            win_valid_q <= 1'b1;
        end else if (win_ready) begin
            win_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            win_beat_q <= win_next;
        end
    end

    assign win_valid = win_valid_q;
    assign win_beat  = win_beat_q;

endmodule

/* design/grad_calc.sv */
`timescale 1ns/1ps

module grad_calc import gi_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      win_valid,
    output logic      win_ready,
    input  win_beat_s win_beat,
    output logic      grad_wr,
    input  logic      grad_ready,
    output grad_wr_s  grad_req,
    output logic      wr_fire
);

    grad_comp_t gx;
    grad_comp_t gy;
    grad_wr_s   req_next;
    logic       load;
    logic       req_valid_q;
    grad_wr_s   req_q;

    // ----------------------------------------------------------------------
    // differences on zero-extended pixels
    // ----------------------------------------------------------------------
    assign gx = grad_comp_t'({2'b00, win_beat.right}) - grad_comp_t'({2'b00, win_beat.cur});
    assign gy = grad_comp_t'({2'b00, win_beat.lower}) - grad_comp_t'({2'b00, win_beat.cur});

    always_comb begin
        req_next.addr = win_beat.addr;
        req_next.data = {gx, gy};
    end

    // ----------------------------------------------------------------------
    // write request register
    // ----------------------------------------------------------------------
    // moves only when empty or draining this cycle
    assign win_ready = !req_valid_q || grad_ready;
    assign load      = win_valid && win_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid_q <= 1'b0;
        end else if (load) begin
            req_valid_q <= 1'b1;
        end else if (grad_ready) begin
            req_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            req_q <= req_next;
        end
    end

    assign grad_wr  = req_valid_q;
    assign grad_req = req_q;
    assign wr_fire  = req_valid_q && grad_ready;

endmodule

/* design/gi_ctrl_regs.sv */
`timescale 1ns/1ps

module gi_ctrl_regs import gi_pkg::*; #(
    parameter int IMG_W = 256,
    parameter int IMG_H = 256
) (
    input  logic clk,
    input  logic reset,
    input  logic cmd_valid,
    output logic cmd_ready,
    input  logic wr_fire,
    output logic frame_start,
    output logic busy,
    output logic done
);

    localparam int FRAME_WORDS = IMG_W * IMG_H;

    ctrl_state_e state_q;
    addr_t       wr_cnt_q;
    logic        last_wr;

    // commands are taken only between frames
    assign cmd_ready   = (state_q == ctrl_idle);
    assign frame_start = cmd_valid && cmd_ready;
    assign busy        = (state_q != ctrl_idle);
    assign done        = (state_q == ctrl_finish);

    assign last_wr = wr_fire && (wr_cnt_q == addr_t'(FRAME_WORDS - 1));

    // ----------------------------------------------------------------------
    // frame FSM and accepted-write count
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q  <= ctrl_idle;
            wr_cnt_q <= '0;
        end else begin
            case (state_q)
                ctrl_idle: begin
                    if (frame_start) begin
                        state_q  <= ctrl_run;
                        wr_cnt_q <= '0;
                    end
                end
                ctrl_run: begin
                    if (wr_fire) begin
                        wr_cnt_q <= wr_cnt_q + 1'b1;
                    end
                    if (last_wr) begin
                        state_q <= ctrl_finish;
                    end
                end
                // one-cycle done pulse
                default: begin
                    state_q <= ctrl_idle;
                end
            endcase
        end
    end

endmodule

/* design/grad_engine_top.sv */
`timescale 1ns/1ps

module grad_engine_top import gi_pkg::*; #(
    parameter int IMG_W = 256,
    parameter int IMG_H = 256
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     cmd_valid,
    output logic     cmd_ready,
    output logic     img_rd,
    output addr_t    img_addr,
    input  pixel_t   img_di,
    output logic     grad_wr,
    input  logic     grad_ready,
    output grad_wr_s grad_req,
    output logic     busy,
    output logic     done
);

    logic      frame_start;
    logic      wr_fire;

    logic      pix_valid;
    logic      pix_ready;
    pix_beat_s pix_beat;

    logic      win_valid;
    logic      win_ready;
    win_beat_s win_beat;

    // ----------------------------------------------------------------------
    // control
    // ----------------------------------------------------------------------
    gi_ctrl_regs #(
        .IMG_W(IMG_W),
        .IMG_H(IMG_H)
    ) u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .wr_fire    (wr_fire),
        .frame_start(frame_start),
        .busy       (busy),
        .done       (done)
    );

    // ----------------------------------------------------------------------
    // datapath: fetch -> window -> difference
    // ----------------------------------------------------------------------
    pixel_fetch #(
        .IMG_W(IMG_W),
        .IMG_H(IMG_H)
    ) u_fetch (
        .clk        (clk),
        .reset      (reset),
        .frame_start(frame_start),
        .img_rd     (img_rd),
        .img_addr   (img_addr),
        .img_di     (img_di),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .pix_beat   (pix_beat)
    );

    window_gen #(
        .IMG_W(IMG_W)
    ) u_window (
        .clk      (clk),
        .reset    (reset),
        .pix_valid(pix_valid),
        .pix_ready(pix_ready),
        .pix_beat (pix_beat),
        .win_valid(win_valid),
        .win_ready(win_ready),
        .win_beat (win_beat)
    );

    grad_calc u_calc (
        .clk       (clk),
        .reset     (reset),
        .win_valid (win_valid),
        .win_ready (win_ready),
        .win_beat  (win_beat),
        .grad_wr   (grad_wr),
        .grad_ready(grad_ready),
        .grad_req  (grad_req),
        .wr_fire   (wr_fire)
    );

endmodule

/* sim/tb_mem_models.sv */
`timescale 1ns/1ps

// image memory, data valid one cycle after the read
module img_rom_model import gi_pkg::*; #(
    parameter int DEPTH = 256
) (
    input  logic   clk,
    input  logic   rd,
    input  addr_t  addr,
    output pixel_t data
);

    pixel_t mem [DEPTH];

    initial begin
        data = '0;
    end

    always @(posedge clk) begin
        if (rd) begin
            data <= #1 mem[addr];
        end
    end

endmodule

// gradient memory with random write-ready and per-address write counts
module grad_ram_model import gi_pkg::*; #(
    parameter int DEPTH = 256,
    parameter int SEED  = 32'h40059f66
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     always_ready,
    input  logic     wr,
    output logic     ready,
    input  grad_wr_s req
);

    grad_t  mem [DEPTH];
    int     wr_count [DEPTH];
    integer seed;

    task clear_counts();
        for (int i = 0; i < DEPTH; i++) begin
            wr_count[i] = 0;
        end
    endtask

    initial begin
        seed  = SEED;
        ready = 1'b0;
        clear_counts();
    end

    always @(posedge clk) begin
        int r;
        r = $random(seed);
        // ready about three cycles in four
        if (reset) begin
            ready <= #1 1'b0;
        end else if (always_ready) begin
            ready <= #1 1'b1;
        end else begin
            ready <= #1 (r[1:0] != 2'b00);
        end
        if (wr && ready && (req.addr < DEPTH)) begin
            mem[req.addr]      <= req.data;
            wr_count[req.addr] <= wr_count[req.addr] + 1;
        end
    end

endmodule

/* sim/tb_grad_engine.sv */
`timescale 1ns/1ps

module tb_grad_engine import gi_pkg::*; ();

    localparam int IMG_W    = 16;
    localparam int IMG_H    = 8;
    localparam int N        = IMG_W * IMG_H;
    localparam int FRAMES   = 3;
    localparam int SEED     = 32'h40059f66;
    localparam int WATCHDOG = FRAMES * 20 * IMG_W * (IMG_H + 1) + 100;

    logic     clk = 1'b0;
    logic     reset;
    logic     cmd_valid;
    logic     cmd_ready;
    logic     img_rd;
    addr_t    img_addr;
    pixel_t   img_di;
    logic     grad_wr;
    logic     grad_ready;
    grad_wr_s grad_req;
    logic     busy;
    logic     done;
    logic     always_ready;

    integer   seed;
    pixel_t   img [N];
    int       starts;
    int       done_count;
    int       frame_writes;
    logic     stalled;
    logic     prev_fire;
    grad_wr_s held_req;
    logic     in_frame;

    always #2 clk = ~clk;

    grad_engine_top #(
        .IMG_W(IMG_W),
        .IMG_H(IMG_H)
    ) dut0 (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_ready(grad_ready),
        .grad_req  (grad_req),
        .busy      (busy),
        .done      (done)
    );

    img_rom_model #(.DEPTH(N)) rom0 (
        .clk (clk),
        .rd  (img_rd),
        .addr(img_addr),
        .data(img_di)
    );

    grad_ram_model #(.DEPTH(N), .SEED(SEED)) ram0 (
        .clk         (clk),
        .reset       (reset),
        .always_ready(always_ready),
        .wr          (grad_wr),
        .ready       (grad_ready),
        .req         (grad_req)
    );

    // ----------------------------------------------------------------------
    // error reporting
    // ----------------------------------------------------------------------
    task stop_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task fail_value(input string name, input logic [63:0] expected, input logic [63:0] got);
        $display("[FAIL] %s expected %0h got %0h", name, expected, got);
        stop_run();
    endtask

    task fail_text(input string msg);
        $display("error: %s", msg);
        stop_run();
    endtask

    // ----------------------------------------------------------------------
    // reference model, edge pixel replicated past the border
    // ----------------------------------------------------------------------
    function automatic grad_t expected_word(input int addr);
        int x;
        int y;
        int p;
        int r;
        int b;
        x = addr % IMG_W;
        y = addr / IMG_W;
        p = img[addr];
        r = p;
        b = p;
        if (x != IMG_W - 1) begin
            r = img[addr + 1];
        end
        if (y != IMG_H - 1) begin
            b = img[addr + IMG_W];
        end
        return {10'(r - p), 10'(b - p)};
    endfunction

    // random frame with saturated pixels mixed in
    task load_image();
        int r;
        for (int i = 0; i < N; i++) begin
            r = $random(seed);
            case (r[3:0])
                4'd0: img[i] = 8'd0;
                4'd1: img[i] = 8'd255;
                default: img[i] = r[11:4];
            endcase
        end
        // full-scale steps of both signs
        img[0]         = 8'd0;
        img[1]         = 8'd255;
        img[IMG_W]     = 8'd255;
        img[2]         = 8'd255;
        img[3]         = 8'd0;
        img[IMG_W + 2] = 8'd0;
        for (int i = 0; i < N; i++) begin
            rom0.mem[i] = img[i];
        end
    endtask

    // ----------------------------------------------------------------------
    // monitor on the DUT ports
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        if (reset) begin
            stalled   <= 1'b0;
            prev_fire <= 1'b0;
            in_frame  <= 1'b0;
        end else begin
            if (img_rd) begin
                assert (img_addr < N)
                else fail_text($sformatf("image read address %0h outside the frame", img_addr));
            end
            assert (!(busy && cmd_ready)) else fail_text("cmd_ready high while busy");
            // busy from the cycle after acceptance through the done cycle
            assert (busy == in_frame) else fail_value("busy", in_frame, busy);
            if (stalled) begin
                assert (grad_wr) else fail_text("grad_wr dropped while stalled");
                assert (grad_req == held_req) else fail_value("grad_req", held_req, grad_req);
            end
            if (grad_wr && grad_ready) begin
                assert (grad_req.addr < N)
                else fail_text($sformatf("write address %0h outside the frame", grad_req.addr));
                assert (grad_req.data == expected_word(grad_req.addr))
                else fail_value($sformatf("grad_req.data[%0h]", grad_req.addr),
                                expected_word(grad_req.addr), grad_req.data);
                frame_writes++;
            end
            if (done) begin
                assert (prev_fire && frame_writes == N)
                else fail_text("done not right after the last write of the frame");
                done_count++;
            end
            if (cmd_valid && cmd_ready) begin
                starts++;
                frame_writes = 0;
                in_frame     <= 1'b1;
            end else if (done) begin
                in_frame <= 1'b0;
            end
            stalled   <= grad_wr && !grad_ready;
            held_req  <= grad_req;
            prev_fire <= grad_wr && grad_ready;
        end
    end

    // hold_cmd keeps cmd_valid high for the whole frame
    task run_frame(input logic hold_cmd);
        @(posedge clk);
        #1 cmd_valid = 1'b1;
        do @(posedge clk); while (!cmd_ready);
        #1;
        if (!hold_cmd) begin
            cmd_valid = 1'b0;
        end
        do @(posedge clk); while (!done);
        #1 cmd_valid = 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task check_frame(input int f);
        assert (done_count == f) else fail_value("done_count", f, done_count);
        assert (starts == f) else fail_value("starts", f, starts);
        for (int a = 0; a < N; a++) begin
            assert (ram0.wr_count[a] == 1)
            else fail_value($sformatf("wr_count[%0h]", a), 1, ram0.wr_count[a]);
            assert (ram0.mem[a] == expected_word(a))
            else fail_value($sformatf("mem[%0h]", a), expected_word(a), ram0.mem[a]);
        end
        ram0.clear_counts();
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        seed         = SEED;
        reset        = 1'b1;
        cmd_valid    = 1'b0;
        always_ready = 1'b0;
        starts       = 0;
        done_count   = 0;
        frame_writes = 0;
        load_image();
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        repeat (2) @(posedge clk);
        assert ({img_rd, grad_wr, done, busy, cmd_ready} == 5'b00001)
        else fail_value("{img_rd,grad_wr,done,busy,cmd_ready}", 5'b00001,
                        {img_rd, grad_wr, done, busy, cmd_ready});
        // frame 2 runs with ready always high and cmd_valid held
        for (int f = 1; f <= FRAMES; f++) begin
            if (f > 1) begin
                load_image();
            end
            #1 always_ready = (f == 2);
            run_frame(f == 2);
            check_frame(f);
        end
        $display("Simulation passed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout: frames not finished after %0d cycles", WATCHDOG);
        stop_run();
    end

endmodule

/* verilog.f */
design/gi_pkg.sv
design/pixel_fetch.sv
design/window_gen.sv
design/grad_calc.sv
design/gi_ctrl_regs.sv
design/grad_engine_top.sv
sim/tb_mem_models.sv
sim/tb_grad_engine.sv
